//--- rv_slice.f
+incdir+testbench
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_id_ex.sv
hdl/rv_exec.sv
hdl/rv_ex_slice.sv
testbench/tb_rv_ex_slice.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f rv_slice.f --top-module tb_rv_ex_slice -Mdir obj_dir -o tb_rv_ex_slice &&
./obj_dir/tb_rv_ex_slice ||
{ echo "simulation failed"; exit 1; }

//--- testbench/tb_program.svh
// one program row, fetched at address 4 * row index
typedef struct packed {
    logic [31:0] inst;
    logic [4:0]  waddr;   // expected writeback index, 0 for none
    logic [31:0] wdata;
    logic        jump;    // taken branch or jump
    logic [31:0] target;
} prog_row_t;

localparam int NUM_ROWS = 31;

// columns: instruction, wb index, wb value, jump taken, jump target
localparam prog_row_t PROG [NUM_ROWS] = '{
    '{32'h0050_0093, 5'd1,  32'h0000_0005, 1'b0, 32'h0000_0000},  // addi x1, x0, 5
    '{32'hFFD0_8113, 5'd2,  32'h0000_0002, 1'b0, 32'h0000_0000},  // addi x2, x1, -3
    '{32'h0020_81B3, 5'd3,  32'h0000_0007, 1'b0, 32'h0000_0000},  // add x3, x1, x2
    '{32'h4031_0233, 5'd4,  32'hFFFF_FFFB, 1'b0, 32'h0000_0000},  // sub x4, x2, x3
    '{32'h8000_12B7, 5'd5,  32'h8000_1000, 1'b0, 32'h0000_0000},  // lui x5, 0x80001
    '{32'h0000_1317, 5'd6,  32'h0000_1014, 1'b0, 32'h0000_0000},  // auipc x6, 0x1
    '{32'h4042_D393, 5'd7,  32'hF800_0100, 1'b0, 32'h0000_0000},  // srai x7, x5, 4
    '{32'h0012_2433, 5'd8,  32'h0000_0001, 1'b0, 32'h0000_0000},  // slt x8, x4, x1
    '{32'h0012_34B3, 5'd9,  32'h0000_0000, 1'b0, 32'h0000_0000},  // sltu x9, x4, x1
    '{32'h0071_C533, 5'd10, 32'hF800_0107, 1'b0, 32'h0000_0000},  // xor x10, x3, x7
    '{32'h0030_9593, 5'd11, 32'h0000_0028, 1'b0, 32'h0000_0000},  // slli x11, x1, 3
    '{32'h0090_8013, 5'd0,  32'h0000_0000, 1'b0, 32'h0000_0000},  // addi x0, x1, 9
    '{32'h0020_8463, 5'd0,  32'h0000_0000, 1'b0, 32'h0000_0000},  // beq x1, x2 not taken
    '{32'h0020_9663, 5'd0,  32'h0000_0000, 1'b1, 32'h0000_0040},  // bne x1, x2, +12
    '{32'h0010_0F93, 5'd31, 32'h0000_0001, 1'b0, 32'h0000_0000},  // flushed
    '{32'h0020_0F93, 5'd31, 32'h0000_0002, 1'b0, 32'h0000_0000},  // never fetched
    '{32'h0012_4463, 5'd0,  32'h0000_0000, 1'b1, 32'h0000_0048},  // blt x4, x1, +8
    '{32'h0030_0F93, 5'd31, 32'h0000_0003, 1'b0, 32'h0000_0000},  // flushed
    '{32'h0012_6463, 5'd0,  32'h0000_0000, 1'b0, 32'h0000_0000},  // bltu x4, x1 not taken
    '{32'h0012_5463, 5'd0,  32'h0000_0000, 1'b0, 32'h0000_0000},  // bge x4, x1 not taken
    '{32'h0012_7463, 5'd0,  32'h0000_0000, 1'b1, 32'h0000_0058},  // bgeu x4, x1, +8
    '{32'h0040_0F93, 5'd31, 32'h0000_0004, 1'b0, 32'h0000_0000},  // flushed
    '{32'h00C0_066F, 5'd12, 32'h0000_005C, 1'b1, 32'h0000_0064},  // jal x12, +12
    '{32'h0050_0F93, 5'd31, 32'h0000_0005, 1'b0, 32'h0000_0000},  // flushed
    '{32'h0060_0F93, 5'd31, 32'h0000_0006, 1'b0, 32'h0000_0000},  // never fetched
    '{32'h0116_06E7, 5'd13, 32'h0000_0068, 1'b1, 32'h0000_006C},  // jalr x13, 0x11(x12)
    '{32'h0070_0F93, 5'd31, 32'h0000_0007, 1'b0, 32'h0000_0000},  // flushed
    '{32'h0016_8713, 5'd14, 32'h0000_0069, 1'b0, 32'h0000_0000},  // addi x14, x13, 1
    '{32'h00C7_67B3, 5'd15, 32'h0000_007D, 1'b0, 32'h0000_0000},  // or x15, x14, x12
    '{32'h0053_F833, 5'd16, 32'h8000_0000, 1'b0, 32'h0000_0000},  // and x16, x7, x5
    '{32'h0012_D8B3, 5'd17, 32'h0400_0080, 1'b0, 32'h0000_0000}   // srl x17, x5, x1
};

//--- testbench/tb_rv_ex_slice.sv
module tb_rv_ex_slice;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 5;
    localparam int          STALL_BUDGET = 16;  // worst-case cycles per row under stall
    localparam logic [31:0] NOP_WORD     = 32'h0000_0013;  // addi x0, x0, 0

    `include "tb_program.svh"

    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * STALL_BUDGET;

    logic        clk;
    logic        arst_n;
    logic [31:0] inst;
    logic [31:0] inst_addr;
    logic        valid;
    logic        stall;
    logic        ready;
    logic        wb_we;
    logic [4:0]  wb_waddr;
    logic [31:0] wb_wdata;
    logic        jump;
    logic [31:0] jump_addr;

    integer seed;
    int     pc;
    int     row;      // row presented this cycle
    int     ex_row;   // row now in EX, -1 when empty

    rv_ex_slice #(
        .NumRegs(32)
    ) i_rv_ex_slice (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .inst_i     (inst),
        .inst_addr_i(inst_addr),
        .valid_i    (valid),
        .stall_i    (stall),
        .ready_o    (ready),
        .wb_we_o    (wb_we),
        .wb_waddr_o (wb_waddr),
        .wb_wdata_o (wb_wdata),
        .jump_o     (jump),
        .jump_addr_o(jump_addr)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s is 0x%08h, expected 0x%08h (pc 0x%08h)",
                     name, actual, expected, pc);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // expected EX outputs follow from the table row held in EX
    task automatic check_ex_stage();
        logic exp_we;
        check_value("ready_o", ready, !stall);
        if (ex_row < 0 || stall) begin
            check_value("wb_we_o", wb_we, 0);  // empty or held stage
            check_value("jump_o", jump, 0);
        end else begin
            exp_we = PROG[ex_row].waddr != 5'd0;
            check_value("wb_we_o", wb_we, exp_we);
            if (exp_we) begin
                check_value("wb_waddr_o", wb_waddr, PROG[ex_row].waddr);
                check_value("wb_wdata_o", wb_wdata, PROG[ex_row].wdata);
            end
            check_value("jump_o", jump, PROG[ex_row].jump);
            if (PROG[ex_row].jump) begin
                check_value("jump_addr_o", jump_addr, PROG[ex_row].target);
            end
        end
    endtask

    // next pc and EX contents after the coming edge
    task automatic advance_model();
        if (!stall) begin
            if (ex_row >= 0 && PROG[ex_row].jump) begin
                pc     = int'(PROG[ex_row].target);
                ex_row = -1;  // presented row is flushed
            end else if (row < NUM_ROWS) begin
                ex_row = row;
                pc     = pc + 4;
            end else begin
                ex_row = -1;
            end
        end
    endtask

    initial begin
        seed      = 32'h5fca;
        arst_n    = 1'b0;
        inst      = NOP_WORD;
        inst_addr = '0;
        valid     = 1'b0;
        stall     = 1'b0;
        pc        = 0;
        row       = 0;
        ex_row    = -1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_value("wb_we_o", wb_we, 0);  // nothing accepted yet
        check_value("jump_o", jump, 0);

        while (!(pc >= NUM_ROWS * 4 && ex_row < 0)) begin
            @(posedge clk);
            #1;
            row   = pc / 4;
            stall = ($random(seed) & 3) == 0;  // about one cycle in four
            if (row < NUM_ROWS) begin
                valid     = 1'b1;
                inst      = PROG[row].inst;
                inst_addr = pc;
            end else begin
                valid     = 1'b0;  // program done, drain
                inst      = NOP_WORD;
                inst_addr = pc;
            end
            @(negedge clk);
            check_ex_stage();
            advance_model();
        end

        $display("No errors");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: program not finished within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- hdl/rv_ex_slice.sv
module rv_ex_slice
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int NumRegs = 32
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic [InstBus-1:0]     inst_i,
    input  logic [InstAddrBus-1:0] inst_addr_i,
    input  logic                   valid_i,
    input  logic                   stall_i,
    output logic                   ready_o,
    output logic                   wb_we_o,
    output logic [RegAddrBus-1:0]  wb_waddr_o,
    output logic [RegBus-1:0]      wb_wdata_o,
    output logic                   jump_o,
    output logic [InstAddrBus-1:0] jump_addr_o
);

    logic [RegAddrBus-1:0] reg1_raddr;
    logic [RegAddrBus-1:0] reg2_raddr;
    logic [RegBus-1:0]     reg1_rdata;
    logic [RegBus-1:0]     reg2_rdata;
    id_ex_t                id_ex_d;      // decoder to stage register
    id_ex_t                id_ex_q;      // stage register to execute
    wb_t                   wb;
    hold_flag_e            hold_flag;
    logic                  ready_ex;

    rv_decoder #(
        .NumRegs(NumRegs)
    ) i_rv_decoder (
        .inst_i,
        .inst_addr_i,
        .reg1_rdata_i(reg1_rdata),
        .reg2_rdata_i(reg2_rdata),
        .reg1_raddr_o(reg1_raddr),
        .reg2_raddr_o(reg2_raddr),
        .id_ex_o     (id_ex_d)
    );

    rv_regfile #(
        .NumRegs(NumRegs)
    ) i_rv_regfile (
        .clk_i,
        .arst_n_i,
        .reg1_raddr_i(reg1_raddr),
        .reg2_raddr_i(reg2_raddr),
        .wb_i        (wb),
        .reg1_rdata_o(reg1_rdata),
        .reg2_rdata_o(reg2_rdata)
    );

    rv_id_ex i_rv_id_ex (
        .clk_i,
        .arst_n_i,
        .ready_ex_i   (ready_ex),
        .valid_if_id_i(valid_i),
        .id_ex_i      (id_ex_d),
        .hold_flag_i  (hold_flag),
        .id_ex_o      (id_ex_q),
        .ready_id_ex_o(ready_o)
    );

    rv_exec i_rv_exec (
        .id_ex_i    (id_ex_q),
        .stall_i,
        .wb_o       (wb),
        .jump_o,
        .jump_addr_o,
        .hold_flag_o(hold_flag),
        .ready_ex_o (ready_ex)
    );

    assign wb_we_o    = wb.we;
    assign wb_waddr_o = wb.waddr;
    assign wb_wdata_o = wb.wdata;

endmodule

//--- hdl/rv_exec.sv
module rv_exec
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  id_ex_t                 id_ex_i,
    input  logic                   stall_i,
    output wb_t                    wb_o,
    output logic                   jump_o,
    output logic [InstAddrBus-1:0] jump_addr_o,
    output hold_flag_e             hold_flag_o,
    output logic                   ready_ex_o
);

    logic [RegBus-1:0]      alu_res;
    logic [4:0]             shamt;
    logic                   taken;
    logic [InstAddrBus-1:0] jump_base;
    logic [InstAddrBus-1:0] jump_sum;

    assign shamt = id_ex_i.op2[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB:    alu_res = id_ex_i.op1 - id_ex_i.op2;
            ALU_AND:    alu_res = id_ex_i.op1 & id_ex_i.op2;
            ALU_OR:     alu_res = id_ex_i.op1 | id_ex_i.op2;
            ALU_XOR:    alu_res = id_ex_i.op1 ^ id_ex_i.op2;
            ALU_SLL:    alu_res = id_ex_i.op1 << shamt;
            ALU_SRL:    alu_res = id_ex_i.op1 >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(id_ex_i.op1) >>> shamt);
            ALU_SLT:    alu_res = {31'b0, $signed(id_ex_i.op1) < $signed(id_ex_i.op2)};
            ALU_SLTU:   alu_res = {31'b0, id_ex_i.op1 < id_ex_i.op2};
            ALU_PASS_B: alu_res = id_ex_i.op2;
            default:    alu_res = id_ex_i.op1 + id_ex_i.op2;  // add, auipc
        endcase
    end

    // branch decision on the raw register values
    always_comb begin
        case (id_ex_i.br_op)
            BR_EQ:     taken = id_ex_i.reg1_rdata == id_ex_i.reg2_rdata;
            BR_NE:     taken = id_ex_i.reg1_rdata != id_ex_i.reg2_rdata;
            BR_LT:     taken = $signed(id_ex_i.reg1_rdata) < $signed(id_ex_i.reg2_rdata);
            BR_GE:     taken = $signed(id_ex_i.reg1_rdata) >= $signed(id_ex_i.reg2_rdata);
            BR_LTU:    taken = id_ex_i.reg1_rdata < id_ex_i.reg2_rdata;
            BR_GEU:    taken = id_ex_i.reg1_rdata >= id_ex_i.reg2_rdata;
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign jump_base   = id_ex_i.jump_base_sel ? id_ex_i.reg1_rdata : id_ex_i.inst_addr;
    assign jump_sum    = jump_base + id_ex_i.imm;
    assign jump_addr_o = jump_sum & {{(InstAddrBus - 1){1'b1}}, ~id_ex_i.jump_base_sel};

    assign ready_ex_o = ~stall_i;
    assign jump_o     = taken && ready_ex_o;  // redirect once the stage retires

    always_comb begin
        if (jump_o) begin
            hold_flag_o = Pipe_Clear;
        end else if (stall_i) begin
            hold_flag_o = Pipe_Hold;
        end else begin
            hold_flag_o = Pipe_None;
        end
    end

    assign wb_o.we    = id_ex_i.reg_we && ready_ex_o && (id_ex_i.reg_waddr != '0);
    assign wb_o.waddr = id_ex_i.reg_waddr;
    assign wb_o.wdata = (id_ex_i.br_op == BR_ALWAYS) ? id_ex_i.inst_addr_next : alu_res;

endmodule

//--- hdl/rv_id_ex.sv
module rv_id_ex
    import rv_pipe_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       ready_ex_i,
    input  logic       valid_if_id_i,
    input  id_ex_t     id_ex_i,
    input  hold_flag_e hold_flag_i,
    output id_ex_t     id_ex_o,
    output logic       ready_id_ex_o
);

    logic   en;
    logic   clear;
    id_ex_t id_ex_q;

    // flush on a taken transfer, or drain when nothing valid arrives
    assign clear = (hold_flag_i == Pipe_Clear) || (ready_ex_i && !valid_if_id_i);
    assign en    = ready_ex_i && valid_if_id_i;

    assign ready_id_ex_o = ready_ex_i;  // no buffering here

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= ID_EX_NOP;
        end else if (clear) begin
            id_ex_q <= ID_EX_NOP;  // clear wins over load
        end else if (en) begin
            id_ex_q <= id_ex_i;
        end
    end

    assign id_ex_o = id_ex_q;

    // execute never flushes while it holds the stage
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !ready_ex_i |=> $stable(id_ex_o))
        else $error("stage contents changed while execute was not ready");

endmodule

//--- hdl/rv_regfile.sv
module rv_regfile
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int NumRegs = 32
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [RegAddrBus-1:0] reg1_raddr_i,
    input  logic [RegAddrBus-1:0] reg2_raddr_i,
    input  wb_t                   wb_i,
    output logic [RegBus-1:0]     reg1_rdata_o,
    output logic [RegBus-1:0]     reg2_rdata_o
);

    localparam int IdxW = $clog2(NumRegs);

    logic [RegBus-1:0] regs [NumRegs];

    always_ff @(posedge clk_i) begin
        if (wb_i.we && wb_i.waddr != '0) begin
            regs[wb_i.waddr[IdxW-1:0]] <= wb_i.wdata;
        end
    end

    // x0 reads zero, a same-cycle write is passed straight through
    function automatic logic [RegBus-1:0] read_port(logic [RegAddrBus-1:0] raddr);
        logic [RegBus-1:0] rdata;
        if (raddr == '0) begin
            rdata = '0;
        end else if (wb_i.we && wb_i.waddr == raddr) begin
            rdata = wb_i.wdata;  // bypass
        end else begin
            rdata = regs[raddr[IdxW-1:0]];
        end
        return rdata;
    endfunction

    always_comb begin
        reg1_rdata_o = read_port(reg1_raddr_i);
        reg2_rdata_o = read_port(reg2_raddr_i);
    end

    // decoder must keep indices inside the implemented set
    a_waddr_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_i.we |-> 32'(wb_i.waddr) < NumRegs)
        else $error("write index %0d beyond %0d registers", wb_i.waddr, NumRegs);

endmodule

//--- hdl/rv_decoder.sv
module rv_decoder
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int NumRegs = 32
) (
    input  logic [InstBus-1:0]     inst_i,
    input  logic [InstAddrBus-1:0] inst_addr_i,
    input  logic [RegBus-1:0]      reg1_rdata_i,
    input  logic [RegBus-1:0]      reg2_rdata_i,
    output logic [RegAddrBus-1:0]  reg1_raddr_o,
    output logic [RegAddrBus-1:0]  reg2_raddr_o,
    output id_ex_t                 id_ex_o
);

    // keeps indices inside the implemented register set
    localparam logic [RegAddrBus-1:0] IdxMask = RegAddrBus'(NumRegs - 1);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [RegAddrBus-1:0] rd;
    logic [RegBus-1:0]     imm_i;
    logic [RegBus-1:0]     imm_u;
    logic [RegBus-1:0]     imm_j;
    logic [RegBus-1:0]     imm_b;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7] & IdxMask;

    assign reg1_raddr_o = inst_i[19:15] & IdxMask;
    assign reg2_raddr_o = inst_i[24:20] & IdxMask;

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    // funct3 to alu op, alt picks sub/sra
    function automatic alu_op_e alu_decode(logic [2:0] f3, logic alt, logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;  // no subi
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        id_ex_o                = ID_EX_NOP;
        id_ex_o.inst_addr      = inst_addr_i;
        id_ex_o.inst_addr_next = inst_addr_i + 32'd4;
        id_ex_o.reg1_rdata     = reg1_rdata_i;
        id_ex_o.reg2_rdata     = reg2_rdata_i;
        id_ex_o.reg_waddr      = rd;
        case (opcode)
            OPC_OP: begin
                id_ex_o.reg_we = 1'b1;
                id_ex_o.op1    = reg1_rdata_i;
                id_ex_o.op2    = reg2_rdata_i;
                id_ex_o.alu_op = alu_decode(funct3, funct7[5], 1'b1);
            end
            OPC_OP_IMM: begin
                id_ex_o.reg_we = 1'b1;
                id_ex_o.op1    = reg1_rdata_i;
                id_ex_o.op2    = imm_i;
                id_ex_o.imm    = imm_i;
                id_ex_o.alu_op = alu_decode(funct3, funct7[5], 1'b0);
            end
            OPC_LUI: begin
                id_ex_o.reg_we = 1'b1;
                id_ex_o.op2    = imm_u;
                id_ex_o.imm    = imm_u;
                id_ex_o.alu_op = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                id_ex_o.reg_we = 1'b1;
                id_ex_o.op1    = inst_addr_i;
                id_ex_o.op2    = imm_u;
                id_ex_o.imm    = imm_u;
            end
            OPC_JAL: begin
                id_ex_o.reg_we = 1'b1;
                id_ex_o.br_op  = BR_ALWAYS;
                id_ex_o.imm    = imm_j;
            end
            OPC_JALR: begin
                id_ex_o.reg_we        = 1'b1;
                id_ex_o.br_op         = BR_ALWAYS;
                id_ex_o.imm           = imm_i;
                id_ex_o.jump_base_sel = 1'b1;  // target from rs1
            end
            OPC_BRANCH: begin
                id_ex_o.imm = imm_b;
                case (funct3)
                    3'b000:  id_ex_o.br_op = BR_EQ;
                    3'b001:  id_ex_o.br_op = BR_NE;
                    3'b100:  id_ex_o.br_op = BR_LT;
                    3'b101:  id_ex_o.br_op = BR_GE;
                    3'b110:  id_ex_o.br_op = BR_LTU;
                    3'b111:  id_ex_o.br_op = BR_GEU;
                    default: id_ex_o.br_op = BR_NONE;
                endcase
            end
            default: begin
                id_ex_o.reg_waddr = '0;  // unknown opcode runs as nop
            end
        endcase
    end

endmodule

//--- hdl/rv_pipe_pkg.sv
package rv_pipe_pkg;
    import rv_isa_pkg::*;

    // pipeline control from execute back to the stage register
    typedef enum logic [1:0] {
        Pipe_None  = 2'b00,
        Pipe_Hold  = 2'b01,  // stalled, keep contents
        Pipe_Clear = 2'b10   // flush after a taken transfer
    } hold_flag_e;

    // contents of the ID/EX stage register
    typedef struct packed {
        logic [InstAddrBus-1:0] inst_addr;
        logic [InstAddrBus-1:0] inst_addr_next;  // link value for jal/jalr
        logic [RegBus-1:0]      op1;
        logic [RegBus-1:0]      op2;
        logic [RegBus-1:0]      reg1_rdata;      // raw values for branch compare
        logic [RegBus-1:0]      reg2_rdata;
        logic                   reg_we;
        logic [RegAddrBus-1:0]  reg_waddr;
        alu_op_e                alu_op;
        br_op_e                 br_op;
        logic                   jump_base_sel;   // 0 pc, 1 reg1
        logic [RegBus-1:0]      imm;
    } id_ex_t;

    // register file write port
    typedef struct packed {
        logic                  we;
        logic [RegAddrBus-1:0] waddr;
        logic [RegBus-1:0]     wdata;
    } wb_t;

    // empty stage, the decoded form of INST_NOP at address zero
    localparam id_ex_t ID_EX_NOP = '{
        inst_addr:      '0,
        inst_addr_next: '0,
        op1:            '0,
        op2:            '0,
        reg1_rdata:     '0,
        reg2_rdata:     '0,
        reg_we:         1'b0,
        reg_waddr:      '0,
        alu_op:         ALU_ADD,
        br_op:          BR_NONE,
        jump_base_sel:  1'b0,
        imm:            '0
    };

endpackage

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // datapath widths
    localparam int InstBus     = 32;  // instruction word
    localparam int RegBus      = 32;  // register data
    localparam int InstAddrBus = 32;  // instruction address
    localparam int RegAddrBus  = 5;   // register index

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // reg-reg alu
        OPC_OP_IMM = 7'b0010011,  // reg-imm alu
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // operation carried out in the execute stage
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B  // lui
    } alu_op_e;

    // branch condition, judged on the two register values
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_ALWAYS  // jal and jalr
    } br_op_e;

    // addi x0, x0, 0
    localparam logic [InstBus-1:0] INST_NOP = 32'h0000_0013;

endpackage
